// ==== files.f ====
+incdir+.
soc_bus_pkg.sv
bus_if.sv
mmc.sv
scratch_ram.sv
io_regs.sv
console_fifo.sv
console_tx.sv
soc_bus_top.sv
tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the soc bus testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_soc_bus -o tb_soc_bus
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_soc_bus > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation passed"
exit 0

// ==== tb_soc_bus.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module tb_soc_bus import soc_bus_pkg::*;;

  localparam int BUS_TIMEOUT   = 400;
  localparam int START_TIMEOUT = 400;

  logic                 clk;
  logic                 rst;
  logic                 bus_req;
  logic                 bus_write;
  logic [31:0]          bus_addr;
  logic [31:0]          bus_wdata;
  logic [3:0]           bus_rd_mask;
  logic [3:0]           bus_wr_mask;
  logic                 bus_ack;
  logic [31:0]          bus_rdata;
  logic [`NUM_KEYS-1:0] keys;
  logic [7:0]           leds;
  logic                 uart_tx;

  logic [31:0] rng;
  logic [31:0] ram_model [`RAM_WORDS];
  logic [7:0]  led_model;

  soc_bus_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_rd_mask (bus_rd_mask),
    .bus_wr_mask (bus_wr_mask),
    .bus_ack     (bus_ack),
    .bus_rdata   (bus_rdata),
    .keys        (keys),
    .leds        (leds),
    .uart_tx     (uart_tx)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic in_range(input logic [31:0] a, input logic [31:0] lo,
                                    input logic [31:0] hi);
    return (a - lo) <= (hi - lo);  // wraps below lo.
  endfunction

  function automatic target_e window_target(input logic [31:0] a);
    if (in_range(a, `RAM_ADDR_LO, `RAM_ADDR_HI))
      return tgt_ram;
    if (in_range(a, `IO_ADDR_LO, `IO_ADDR_HI))
      return tgt_io;
    if (in_range(a, `CONSOLE_ADDR_LO, `CONSOLE_ADDR_HI))
      return tgt_console;
    return tgt_none;
  endfunction

  function automatic logic [31:0] rand_addr(input target_e t);
    logic [31:0] a;
    case (t)
      tgt_ram:     a = `RAM_ADDR_LO + (next_rand() % (`RAM_ADDR_HI - `RAM_ADDR_LO + 1));
      tgt_io:      a = `IO_ADDR_LO + (next_rand() % (`IO_ADDR_HI - `IO_ADDR_LO + 1));
      tgt_console: a = `CONSOLE_ADDR_LO;
      default:
      begin
        a = next_rand();
        while (window_target(a) != tgt_none)
          a = next_rand();
      end
    endcase
    return a & ~32'h3;
  endfunction

  function automatic int ram_index(input logic [31:0] a);
    return int'(((a - `RAM_ADDR_LO) >> 2) % `RAM_WORDS);  // aliases past 256 words.
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] mask);
    logic [31:0] w;
    w = old;
    for (int l = 0; l < 4; l++)
      if (mask[l])
        w[8*l +: 8] = d[8*l +: 8];
    return w;
  endfunction

  function automatic logic [31:0] status_word(input logic full, input logic busy,
                                              input int count);
    return (32'(count) << 4) | (32'(busy) << 1) | 32'(full);
  endfunction

  task automatic fail_stop();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // one request, counted in cycles until ack, then two idle cycles.
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wr_mask,
                            output logic [31:0] rdata, output int cycles);
    bus_req     = 1'b1;
    bus_write   = write;
    bus_addr    = addr;
    bus_wdata   = wdata;
    bus_rd_mask = 4'hf;
    bus_wr_mask = wr_mask;
    cycles      = 0;
    do
    begin
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
    while (!bus_ack && cycles < BUS_TIMEOUT);
    if (!bus_ack)
    begin
      $display("no bus_ack within %0d cycles for address %h", BUS_TIMEOUT, addr);
      fail_stop();
    end
    rdata = bus_rdata;
    @(posedge clk);
    #1;
    bus_req = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic recv_char(output logic [7:0] ch);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (uart_tx !== 1'b0 && n < START_TIMEOUT);
    if (uart_tx !== 1'b0)
    begin
      $display("no start bit on uart_tx within %0d cycles", START_TIMEOUT);
      fail_stop();
    end
    repeat (`BAUD_DIV / 2 - 1) @(negedge clk);  // middle of start bit.
    check("uart_tx start bit", 32'(uart_tx), 32'd0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (`BAUD_DIV) @(negedge clk);
      ch[i] = uart_tx;
    end
    repeat (`BAUD_DIV) @(negedge clk);
    check("uart_tx stop bit", 32'(uart_tx), 32'd1);
  endtask

  task automatic console_burst(input int n);
    logic [7:0]  chars [$];
    logic [7:0]  got;
    logic [31:0] r;
    logic [31:0] rd;
    int          cyc;
    for (int k = 0; k < n; k++)
    begin
      r = next_rand();
      chars.push_back(r[7:0]);
    end
    @(posedge clk);
    #1;
    fork
      begin
        for (int k = 0; k < n; k++)
        begin
          if (k == `FIFO_DEPTH + 1)
          begin
            bus_access(1'b0, `CONSOLE_ADDR_LO, 32'd0, 4'h0, rd, cyc);
            check("console status", rd, status_word(1'b1, 1'b1, `FIFO_DEPTH));
            check("console read ack latency", 32'(cyc), 32'd1);
          end
          r = next_rand();
          bus_access(1'b1, `CONSOLE_ADDR_LO, {r[31:8], chars[k]}, 4'h1, rd, cyc);
          if (k <= `FIFO_DEPTH)
            check("console write ack latency", 32'(cyc), 32'd1);
          else
            check("console write held while full", 32'(cyc > 1), 32'd1);
        end
      end
      begin
        for (int k = 0; k < n; k++)
        begin
          recv_char(got);
          check("uart_tx character", 32'(got), 32'(chars[k]));
        end
      end
    join
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] rd;
    int          cyc;
    int          idx;
    rng         = 32'h7c;
    rst         = 1'b1;
    bus_req     = 1'b0;
    bus_write   = 1'b0;
    bus_addr    = '0;
    bus_wdata   = '0;
    bus_rd_mask = '0;
    bus_wr_mask = '0;
    keys        = '0;
    led_model   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check("bus_ack", 32'(bus_ack), 32'd0);
    check("uart_tx", 32'(uart_tx), 32'd1);
    check("leds", 32'(leds), 32'd0);
    @(posedge clk);
    #1;

    for (int i = 0; i < `RAM_WORDS; i++)
    begin
      d = next_rand();
      bus_access(1'b1, `RAM_ADDR_LO + 32'(i) * 4, d, 4'hf, rd, cyc);
      check("ram ack latency", 32'(cyc), 32'd1);
      ram_model[i] = d;
    end
    for (int n = 0; n < 300; n++)
    begin
      a   = rand_addr(tgt_ram);
      d   = next_rand();
      r   = next_rand();
      idx = ram_index(a);
      bus_access(r[4], a, d, r[3:0], rd, cyc);
      check("ram ack latency", 32'(cyc), 32'd1);
      if (r[4])
        ram_model[idx] = merge_lanes(ram_model[idx], d, r[3:0]);
      else
        check("ram read data", rd, ram_model[idx]);
    end

    for (int n = 0; n < 20; n++)
    begin
      d = next_rand();
      r = next_rand();
      bus_access(1'b1, `IO_ADDR_LO, d, r[3:0], rd, cyc);
      check("io ack latency", 32'(cyc), 32'd1);
      if (r[0])
        led_model = d[7:0];
      check("leds", 32'(leds), 32'(led_model));
      bus_access(1'b0, `IO_ADDR_LO, 32'd0, 4'h0, rd, cyc);
      check("led register read", rd, 32'(led_model));
      check("io ack latency", 32'(cyc), 32'd1);
      keys = r[8 +: `NUM_KEYS];
      repeat (3) @(posedge clk);  // two sync flops plus margin.
      #1;
      bus_access(1'b0, `IO_ADDR_LO + 32'd4, 32'd0, 4'h0, rd, cyc);
      check("key register read", rd, 32'(keys));
      check("io ack latency", 32'(cyc), 32'd1);
      bus_access(1'b1, `IO_ADDR_LO + 32'd4, next_rand(), 4'hf, rd, cyc);
      check("leds", 32'(leds), 32'(led_model));
      check("io ack latency", 32'(cyc), 32'd1);
      a = rand_addr(tgt_io);
      if ((a - `IO_ADDR_LO) > 32'd4)
      begin
        bus_access(1'b0, a, 32'd0, 4'h0, rd, cyc);
        check("unused io offset read", rd, 32'd0);
        check("io ack latency", 32'(cyc), 32'd1);
      end
    end

    for (int n = 0; n < 30; n++)
    begin
      a = rand_addr(tgt_none);
      r = next_rand();
      bus_access(r[0], a, next_rand(), 4'hf, rd, cyc);
      check("unmapped ack latency", 32'(cyc), 32'd1);
      check("unmapped read data", rd, 32'd0);
      idx = int'((a >> 2) % `RAM_WORDS);
      bus_access(1'b0, `RAM_ADDR_LO + 32'(idx) * 4, 32'd0, 4'h0, rd, cyc);
      check("ram read data", rd, ram_model[idx]);
      check("ram ack latency", 32'(cyc), 32'd1);
      check("leds", 32'(leds), 32'(led_model));
    end

    console_burst(3);
    console_burst(6);
    repeat (2 * `BAUD_DIV) @(posedge clk);
    #1;
    bus_access(1'b0, `CONSOLE_ADDR_LO, 32'd0, 4'h0, rd, cyc);
    check("console status", rd, status_word(1'b0, 1'b0, 0));
    check("console read ack latency", 32'(cyc), 32'd1);
    check("uart_tx", 32'(uart_tx), 32'd1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_bus_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module soc_bus_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 bus_req,
  input  logic                 bus_write,
  input  logic [31:0]          bus_addr,
  input  logic [31:0]          bus_wdata,
  input  logic [3:0]           bus_rd_mask,
  input  logic [3:0]           bus_wr_mask,
  output logic                 bus_ack,
  output logic [31:0]          bus_rdata,
  input  logic [`NUM_KEYS-1:0] keys,
  output logic [7:0]           leds,
  output logic                 uart_tx
);

  logic                                 fifo_push;
  logic [7:0]                           push_char;
  logic                                 fifo_pop;
  logic [7:0]                           head_char;
  logic                                 fifo_empty;
  logic                                 fifo_full;
  logic [$clog2(`FIFO_DEPTH + 1)-1:0]   fifo_count;
  logic                                 tx_busy;

  bus_if ram_bus ();
  bus_if io_bus ();

  mmc mmc0 (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (bus_req),
    .cpu_write   (bus_write),
    .cpu_addr    (bus_addr),
    .cpu_wdata   (bus_wdata),
    .cpu_rd_mask (bus_rd_mask),
    .cpu_wr_mask (bus_wr_mask),
    .cpu_ack     (bus_ack),
    .cpu_rdata   (bus_rdata),
    .ram         (ram_bus.master),
    .io          (io_bus.master),
    .fifo_push   (fifo_push),
    .push_char   (push_char),
    .fifo_full   (fifo_full),
    .fifo_count  (fifo_count),
    .tx_busy     (tx_busy)
  );

  scratch_ram ram0 (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.target)
  );

  io_regs io0 (
    .clk  (clk),
    .rst  (rst),
    .bus  (io_bus.target),
    .keys (keys),
    .leds (leds)
  );

  console_fifo fifo0 (
    .clk       (clk),
    .rst       (rst),
    .push      (fifo_push),
    .push_char (push_char),
    .pop       (fifo_pop),
    .head_char (head_char),
    .empty     (fifo_empty),
    .full      (fifo_full),
    .count     (fifo_count)
  );

  console_tx tx0 (
    .clk       (clk),
    .rst       (rst),
    .empty     (fifo_empty),
    .head_char (head_char),
    .pop       (fifo_pop),
    .busy      (tx_busy),
    .uart_tx   (uart_tx)
  );

endmodule

`default_nettype wire

// ==== console_tx.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module console_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       empty,
  input  logic [7:0] head_char,
  output logic       pop,
  output logic       busy,
  output logic       uart_tx
);

  localparam int BAUD_W = $clog2(`BAUD_DIV);
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_start = 2'd1;
  localparam logic [1:0] st_data  = 2'd2;
  localparam logic [1:0] st_stop  = 2'd3;

  logic [1:0]        state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [7:0]        shift;
  logic              pop_r;
  logic              tx_r;
  logic              baud_last;

  assign baud_last = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));
  assign pop       = pop_r;
  assign busy      = (state != st_idle) | pop_r;
  assign uart_tx   = tx_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= st_idle;
      pop_r    <= 1'b0;
      tx_r     <= 1'b1;  // line idles high.
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      pop_r <= 1'b0;
      case (state)
        st_idle:
          if (pop_r)
          begin
            state    <= st_start;
            tx_r     <= 1'b0;
            baud_cnt <= '0;
          end
          else if (~empty)
            pop_r <= 1'b1;
        st_start:
          if (baud_last)
          begin
            state    <= st_data;
            tx_r     <= shift[0];
            bit_cnt  <= '0;
            baud_cnt <= '0;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        st_data:
          if (baud_last)
          begin
            baud_cnt <= '0;
            if (bit_cnt == 3'd7)
            begin
              state <= st_stop;
              tx_r  <= 1'b1;
            end
            else
            begin
              bit_cnt <= bit_cnt + 3'd1;
              tx_r    <= shift[1];  // next lsb after the shift.
            end
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        st_stop:
          if (baud_last)
          begin
            state    <= st_idle;
            baud_cnt <= '0;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == st_idle) & pop_r)
      shift <= head_char;
    else if ((state == st_data) & baud_last)
      shift <= {1'b0, shift[7:1]};
  end

endmodule

`default_nettype wire

// ==== console_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module console_fifo (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic [7:0] push_char,
  input  logic       pop,
  output logic [7:0] head_char,
  output logic       empty,
  output logic       full,
  output logic [$clog2(`FIFO_DEPTH + 1)-1:0] count
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  logic [7:0]       mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(`FIFO_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign head_char = mem[rd_ptr];
  assign empty     = (cnt == '0);
  assign full      = (cnt == CNT_W'(`FIFO_DEPTH));
  assign count     = cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (push & ~pop)
        cnt <= cnt + 1'b1;
      else if (pop & ~push)
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_char;
  end

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module io_regs (
  input  logic                 clk,
  input  logic                 rst,
  bus_if.target                bus,
  input  logic [`NUM_KEYS-1:0] keys,
  output logic [7:0]           leds
);

  logic [`NUM_KEYS-1:0] key_meta;
  logic [`NUM_KEYS-1:0] key_sync;
  logic [7:0]           led_r;
  logic [13:0]          word_off;
  logic                 accept;
  logic                 ack_r;
  logic                 ack_q;
  logic [31:0]          rdata_r;

  assign word_off  = bus.addr[15:2];
  assign accept    = bus.req & ~ack_r & ~ack_q;
  assign bus.ack   = ack_r;
  assign bus.rdata = rdata_r;
  assign leds      = led_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_r <= 1'b0;
      ack_q <= 1'b0;
      led_r <= '0;
    end
    else
    begin
      ack_r <= accept;
      ack_q <= ack_r;
      if (accept & bus.write & bus.wr_mask[0] & (word_off == 14'd0))
        led_r <= bus.wdata[7:0];
    end
  end

  always_ff @(posedge clk)
  begin
    key_meta <= keys;  // two flop synchroniser.
    key_sync <= key_meta;
    if (accept)
    begin
      if (word_off == 14'd0)
        rdata_r <= {24'd0, led_r};
      else if (word_off == 14'd1)
        rdata_r <= 32'(key_sync);
      else
        rdata_r <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== scratch_ram.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module scratch_ram import soc_bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  bus_if.target bus
);

  localparam int IDX_W = $clog2(`RAM_WORDS);

  bus_word_u        mem [`RAM_WORDS];
  bus_word_u        wr_word;
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             ack_r;
  logic             ack_q;
  logic [31:0]      rdata_r;

  assign wr_word   = bus.wdata;
  assign idx       = bus.addr[IDX_W+1:2];  // upper window bits alias.
  assign accept    = bus.req & ~ack_r & ~ack_q;
  assign bus.ack   = ack_r;
  assign bus.rdata = rdata_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_r <= 1'b0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_r <= accept;
      ack_q <= ack_r;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rdata_r <= mem[idx].word;
      if (bus.write)
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (bus.wr_mask[i])
            mem[idx].bytes[i] <= wr_word.bytes[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== mmc.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "soc_bus_macros.svh"

module mmc import soc_bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_req,
  input  logic        cpu_write,
  input  logic [31:0] cpu_addr,
  input  logic [31:0] cpu_wdata,
  input  logic [3:0]  cpu_rd_mask,
  input  logic [3:0]  cpu_wr_mask,
  output logic        cpu_ack,
  output logic [31:0] cpu_rdata,
  bus_if.master       ram,
  bus_if.master       io,
  output logic        fifo_push,
  output logic [7:0]  push_char,
  input  logic        fifo_full,
  input  logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_count,
  input  logic        tx_busy
);

  target_e     tgt;
  bus_word_u   cpu_word;
  logic        con_req;
  logic        con_ack;
  logic        con_ack_q;
  logic        null_ack;
  logic        null_ack_q;
  logic [31:0] con_status;

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] lo,
                                     input logic [31:0] hi);
    return (addr >= lo) && (addr <= hi);
  endfunction

  always_comb
  begin
    if (in_window(cpu_addr, `RAM_ADDR_LO, `RAM_ADDR_HI))
      tgt = tgt_ram;
    else if (in_window(cpu_addr, `IO_ADDR_LO, `IO_ADDR_HI))
      tgt = tgt_io;
    else if (in_window(cpu_addr, `CONSOLE_ADDR_LO, `CONSOLE_ADDR_HI))
      tgt = tgt_console;
    else
      tgt = tgt_none;
  end

  always_comb
  begin
    ram.req     = cpu_req & (tgt == tgt_ram);
    ram.write   = cpu_write;
    ram.addr    = cpu_addr - `RAM_ADDR_LO;
    ram.wdata   = cpu_wdata;
    ram.rd_mask = cpu_rd_mask;
    ram.wr_mask = cpu_wr_mask;

    io.req      = cpu_req & (tgt == tgt_io);
    io.write    = cpu_write;
    io.addr     = cpu_addr - `IO_ADDR_LO;
    io.wdata    = cpu_wdata;
    io.rd_mask  = cpu_rd_mask;
    io.wr_mask  = cpu_wr_mask;
  end

  assign con_req    = cpu_req & (tgt == tgt_console);
  assign cpu_word   = cpu_wdata;
  assign push_char  = cpu_word.bytes[0];  // character rides in lane 0.
  assign fifo_push  = con_ack & cpu_write;
  assign con_status = 32'({fifo_count, 2'b00, tx_busy, fifo_full});

  // console register and null responder.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      con_ack    <= 1'b0;
      con_ack_q  <= 1'b0;
      null_ack   <= 1'b0;
      null_ack_q <= 1'b0;
    end
    else
    begin
      con_ack    <= con_req & ~con_ack & ~con_ack_q & (~cpu_write | ~fifo_full);
      con_ack_q  <= con_ack;
      null_ack   <= cpu_req & (tgt == tgt_none) & ~null_ack & ~null_ack_q;
      null_ack_q <= null_ack;
    end
  end

  always_comb
  begin
    cpu_ack   = 1'b0;
    cpu_rdata = '0;
    if (ram.ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = ram.rdata;
    end
    else if (io.ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = io.rdata;
    end
    else if (con_ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = con_status;
    end
    else if (null_ack)
      cpu_ack = 1'b1;  // data stays zero.
  end

endmodule

`default_nettype wire

// ==== bus_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface bus_if;

  logic        req;
  logic        write;
  logic [31:0] addr;     // offset inside the target window.
  logic [31:0] wdata;
  logic [3:0]  rd_mask;
  logic [3:0]  wr_mask;
  logic        ack;      // one cycle pulse.
  logic [31:0] rdata;

  modport master (
    output req,
    output write,
    output addr,
    output wdata,
    output rd_mask,
    output wr_mask,
    input  ack,
    input  rdata
  );

  modport target (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    input  rd_mask,
    input  wr_mask,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// ==== soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  // one bus word, seen whole or as byte lanes.
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } bus_word_u;

  // decoded target of a cpu request.
  typedef enum logic [1:0] {
    tgt_ram,
    tgt_io,
    tgt_console,
    tgt_none
  } target_e;

endpackage

`default_nettype wire

// ==== soc_bus_macros.svh ====
`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// scratch RAM window, 16 KiB decoded.
`define RAM_ADDR_LO      32'h0000_0000
`define RAM_ADDR_HI      32'h0000_3FFF

// LED and key registers.
`define IO_ADDR_LO       32'hC000_0000
`define IO_ADDR_HI       32'hC000_FFFF

// console transmitter.
`define CONSOLE_ADDR_LO  32'hC304_0000
`define CONSOLE_ADDR_HI  32'hC304_FFFF

// words actually built, aliased across the window.
`define RAM_WORDS        256

// kept small so a short burst fills it.
`define FIFO_DEPTH       4

// clocks per serial bit.
`define BAUD_DIV         8

`define NUM_KEYS         4

`endif
